// File: compile.f
+incdir+include
logic/cpu_pkg.sv
logic/wb_if.sv
logic/alu.sv
logic/register_file.sv
logic/control_unit.sv
logic/datapath.sv
logic/memory_arbiter.sv
logic/cpu_top.sv
tests/cpu_top_sva.sv
tests/cpu_top_tb.sv

// File: include/cpu_defs.svh
/*
  cpu core constants
  widths, register count, reset fetch address and the HALT opcode value
*/

`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// data word and bus address width
`define WORD_W 32

// register index width and register count
`define REG_ADDR_W 5
`define NUM_REGS 32

// byte address of the first fetch
`define PC_RESET 32'h0000_0000

`define HALT_OPCODE 6'h3f

`endif

// File: logic/alu.sv
/*
  alu
  add, sub, logic ops, signed set-less-than and upper immediate load,
  with a zero flag for branch compares
*/

`timescale 1ns/1ps
`include "cpu_defs.svh"

module alu (
  input  logic [`WORD_W-1:0] a,
  input  logic [`WORD_W-1:0] b,
  input  cpu_pkg::alu_op_t   op,
  output logic [`WORD_W-1:0] result,
  output logic               zero
);

  always_comb begin
    case (op)
      cpu_pkg::ALU_ADD: result = a + b;
      cpu_pkg::ALU_SUB: result = a - b;
      cpu_pkg::ALU_AND: result = a & b;
      cpu_pkg::ALU_OR:  result = a | b;
      cpu_pkg::ALU_XOR: result = a ^ b;
      // signed compare
      cpu_pkg::ALU_SLT: result = {{(`WORD_W-1){1'b0}}, $signed(a) < $signed(b)};
      // immediate goes to the upper half
      cpu_pkg::ALU_LUI: result = {b[15:0], {(`WORD_W-16){1'b0}}};
      default:          result = '0;
    endcase
  end

  assign zero = (result == '0);

endmodule

// File: logic/control_unit.sv
/*
  control unit
  decodes opcode and function fields into the control word,
  unknown encodings decode as a no-op
*/

`timescale 1ns/1ps
`include "cpu_defs.svh"

module control_unit (
  input  logic [`WORD_W-1:0] instr,
  output cpu_pkg::ctrl_t     ctrl
);

  always_comb begin
    // no-op, alu_op defaults to add
    ctrl = '0;
    case (cpu_pkg::opcode_t'(instr[31:26]))
      cpu_pkg::RTYPE: begin
        ctrl.reg_write = 1'b1;
        case (cpu_pkg::funct_t'(instr[5:0]))
          cpu_pkg::ADDU: ctrl.alu_op = cpu_pkg::ALU_ADD;
          cpu_pkg::SUBU: ctrl.alu_op = cpu_pkg::ALU_SUB;
          cpu_pkg::AND:  ctrl.alu_op = cpu_pkg::ALU_AND;
          cpu_pkg::OR:   ctrl.alu_op = cpu_pkg::ALU_OR;
          cpu_pkg::XOR:  ctrl.alu_op = cpu_pkg::ALU_XOR;
          cpu_pkg::SLT:  ctrl.alu_op = cpu_pkg::ALU_SLT;
          default:       ctrl.reg_write = 1'b0;
        endcase
      end
      cpu_pkg::ADDIU, cpu_pkg::LW: begin
        ctrl.alu_src_imm = 1'b1;
        ctrl.sign_extend = 1'b1;
        ctrl.reg_write   = 1'b1;
        ctrl.dest_rt     = 1'b1;
        ctrl.mem_read    = (instr[31:26] == cpu_pkg::LW);
      end
      cpu_pkg::ORI: begin
        ctrl.alu_op      = cpu_pkg::ALU_OR;
        ctrl.alu_src_imm = 1'b1;
        ctrl.reg_write   = 1'b1;
        ctrl.dest_rt     = 1'b1;
      end
      cpu_pkg::LUI: begin
        ctrl.alu_op      = cpu_pkg::ALU_LUI;
        ctrl.alu_src_imm = 1'b1;
        ctrl.reg_write   = 1'b1;
        ctrl.dest_rt     = 1'b1;
      end
      cpu_pkg::SW: begin
        ctrl.alu_src_imm = 1'b1;
        ctrl.sign_extend = 1'b1;
        ctrl.mem_write   = 1'b1;
      end
      // compare by subtraction, offset sign extended
      cpu_pkg::BEQ, cpu_pkg::BNE: begin
        ctrl.alu_op      = cpu_pkg::ALU_SUB;
        ctrl.sign_extend = 1'b1;
        ctrl.branch_eq   = (instr[31:26] == cpu_pkg::BEQ);
        ctrl.branch_ne   = (instr[31:26] == cpu_pkg::BNE);
      end
      cpu_pkg::J:    ctrl.jump = 1'b1;
      cpu_pkg::HALT: ctrl.halt = 1'b1;
      default:       ctrl = '0;
    endcase
  end

endmodule

// File: logic/cpu_pkg.sv
/*
  cpu types
  opcode, function and alu encodings, arbiter states and the
  decoded control word passed down the pipeline
*/

`include "cpu_defs.svh"

package cpu_pkg;

  // opcode field, bits 31:26
  typedef enum logic [5:0] {
    RTYPE = 6'h00,
    J     = 6'h02,
    BEQ   = 6'h04,
    BNE   = 6'h05,
    ADDIU = 6'h09,
    ORI   = 6'h0d,
    LUI   = 6'h0f,
    LW    = 6'h23,
    SW    = 6'h2b,
    HALT  = `HALT_OPCODE
  } opcode_t;

  // r-type function field, bits 5:0
  typedef enum logic [5:0] {
    ADDU = 6'h21,
    SUBU = 6'h23,
    AND  = 6'h24,
    OR   = 6'h25,
    XOR  = 6'h26,
    SLT  = 6'h2a
  } funct_t;

  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_SUB = 3'd1,
    ALU_AND = 3'd2,
    ALU_OR  = 3'd3,
    ALU_XOR = 3'd4,
    ALU_SLT = 3'd5,
    ALU_LUI = 3'd6
  } alu_op_t;

  typedef struct packed {
    alu_op_t alu_op;
    logic    alu_src_imm;
    logic    sign_extend;
    logic    reg_write;
    logic    dest_rt;
    logic    mem_read;
    logic    mem_write;
    logic    branch_eq;
    logic    branch_ne;
    logic    jump;
    logic    halt;
  } ctrl_t;

  typedef enum logic [1:0] {
    ARB_IDLE  = 2'd0,
    ARB_INSTR = 2'd1,
    ARB_DATA  = 2'd2
  } arb_state_t;

endpackage

// File: logic/cpu_top.sv
/*
  cpu top
  pipelined core and bus arbiter on one external wishbone port
*/

`timescale 1ns/1ps
`include "cpu_defs.svh"

module cpu_top (
  input  logic               CLK,
  input  logic               nRST,
  output logic               wb_cyc,
  output logic               wb_stb,
  output logic               wb_we,
  output logic [`WORD_W-1:0] wb_adr,
  output logic [`WORD_W-1:0] wb_wdat,
  input  logic [`WORD_W-1:0] wb_rdat,
  input  logic               wb_ack,
  output logic               halt
);

  // fetch and data buses between core and arbiter
  wb_if ibus_if ();
  wb_if dbus_if ();

  datapath u_datapath (
    .CLK, .nRST,
    .ibus(ibus_if.master),
    .dbus(dbus_if.master),
    .halt
  );

  memory_arbiter u_memory_arbiter (
    .CLK, .nRST,
    .ibus(ibus_if.slave),
    .dbus(dbus_if.slave),
    .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_wdat,
    .wb_rdat, .wb_ack
  );

endmodule

// File: logic/datapath.sv
/*
  datapath
  three stages: fetch, decode/execute, memory/writeback
  fetch and data access are separate wishbone masters; the whole
  pipeline advances only once every pending access has been acked
*/

`timescale 1ns/1ps
`include "cpu_defs.svh"

module datapath (
  input  logic CLK,
  input  logic nRST,
  wb_if.master ibus,
  wb_if.master dbus,
  output logic halt
);

  // fetch
  logic [`WORD_W-1:0] pc, pc_plus4, ibuf, fetch_instr;
  logic               f_done;
  // decode/execute
  logic                   dx_valid, alu_zero, taken;
  logic [`WORD_W-1:0]     dx_instr, dx_pc4;
  cpu_pkg::ctrl_t         dx_ctrl;
  logic [`REG_ADDR_W-1:0] rs, rt, dx_dest;
  logic [`WORD_W-1:0]     rdat1, rdat2, op_a, op_b, imm_ext, alu_b, alu_result;
  logic [`WORD_W-1:0]     branch_target, jump_target;
  // memory/writeback
  logic                   mw_valid, d_done, d_need, wb_en, advance;
  cpu_pkg::ctrl_t         mw_ctrl;
  logic [`REG_ADDR_W-1:0] mw_dest;
  logic [`WORD_W-1:0]     mw_result, mw_store, load_q, load_val, wb_val;

  control_unit u_control_unit (.instr(dx_instr), .ctrl(dx_ctrl));

  register_file u_register_file (
    .CLK, .nRST,
    .rsel1(rs), .rsel2(rt), .rdat1, .rdat2,
    .wen(wb_en), .wsel(mw_dest), .wdat(wb_val)
  );

  alu u_alu (
    .a(op_a), .b(alu_b), .op(dx_ctrl.alu_op), .result(alu_result), .zero(alu_zero)
  );

  assign pc_plus4    = pc + `WORD_W'd4;
  assign fetch_instr = f_done ? ibuf : ibus.rdat;

  assign rs      = dx_instr[25:21];
  assign rt      = dx_instr[20:16];
  assign dx_dest = dx_ctrl.dest_rt ? rt : dx_instr[15:11];

  // load data straight off the bus on the ack cycle, else the captured copy
  assign load_val = d_done ? load_q : dbus.rdat;
  assign wb_val   = mw_ctrl.mem_read ? load_val : mw_result;
  assign wb_en    = advance & mw_valid & mw_ctrl.reg_write;

  // forwarding from memory/writeback
  always_comb begin
    op_a = rdat1;
    op_b = rdat2;
    if (mw_valid && mw_ctrl.reg_write && mw_dest != '0) begin
      if (mw_dest == rs) begin
        op_a = wb_val;
      end
      if (mw_dest == rt) begin
        op_b = wb_val;
      end
    end
  end

  assign imm_ext = dx_ctrl.sign_extend ? {{(`WORD_W-16){dx_instr[15]}}, dx_instr[15:0]}
                                       : {{(`WORD_W-16){1'b0}}, dx_instr[15:0]};
  assign alu_b   = dx_ctrl.alu_src_imm ? imm_ext : op_b;

  // branch and jump resolved here, no delay slot
  assign branch_target = dx_pc4 + {imm_ext[`WORD_W-3:0], 2'b00};
  assign jump_target   = {dx_pc4[`WORD_W-1:`WORD_W-4], dx_instr[25:0], 2'b00};
  assign taken = dx_valid & (dx_ctrl.jump | (dx_ctrl.branch_eq & alu_zero) |
                             (dx_ctrl.branch_ne & ~alu_zero));

  // stall until fetch and any data access are both acked
  assign d_need  = mw_valid & (mw_ctrl.mem_read | mw_ctrl.mem_write);
  assign advance = ~halt & (f_done | ibus.ack) & (~d_need | d_done | dbus.ack);

  // fetch master
  assign ibus.cyc  = ~halt & ~f_done;
  assign ibus.stb  = ~halt & ~f_done;
  assign ibus.we   = 1'b0;
  assign ibus.adr  = {2'b00, pc[`WORD_W-1:2]};
  assign ibus.wdat = '0;

  // data master
  assign dbus.cyc  = d_need & ~d_done;
  assign dbus.stb  = d_need & ~d_done;
  assign dbus.we   = mw_ctrl.mem_write;
  assign dbus.adr  = {2'b00, mw_result[`WORD_W-1:2]};
  assign dbus.wdat = mw_store;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      pc       <= `PC_RESET;
      f_done   <= 1'b0;
      d_done   <= 1'b0;
      dx_valid <= 1'b0;
      mw_valid <= 1'b0;
      mw_ctrl  <= '0;
      halt     <= 1'b0;
    end else if (advance) begin
      pc       <= taken ? (dx_ctrl.jump ? jump_target : branch_target) : pc_plus4;
      f_done   <= 1'b0;
      d_done   <= 1'b0;
      // squash the fetched instruction on a redirect
      dx_valid <= ~taken;
      mw_valid <= dx_valid;
      mw_ctrl  <= dx_valid ? dx_ctrl : '0;
      halt     <= dx_valid & dx_ctrl.halt;
    end else begin
      f_done <= f_done | ibus.ack;
      d_done <= d_done | dbus.ack;
    end
  end

  always_ff @(posedge CLK) begin
    if (ibus.ack) begin
      ibuf <= ibus.rdat;
    end
    if (dbus.ack) begin
      load_q <= dbus.rdat;
    end
    if (advance) begin
      dx_instr  <= fetch_instr;
      dx_pc4    <= pc_plus4;
      mw_dest   <= dx_dest;
      mw_result <= alu_result;
      mw_store  <= op_b;
    end
  end

endmodule

// File: logic/memory_arbiter.sv
/*
  memory arbiter
  shares one wishbone bus between fetch and data masters,
  data wins in idle, grant held until ack
*/

`timescale 1ns/1ps
`include "cpu_defs.svh"

module memory_arbiter (
  input  logic               CLK,
  input  logic               nRST,
  wb_if.slave                ibus,
  wb_if.slave                dbus,
  output logic               wb_cyc,
  output logic               wb_stb,
  output logic               wb_we,
  output logic [`WORD_W-1:0] wb_adr,
  output logic [`WORD_W-1:0] wb_wdat,
  input  logic [`WORD_W-1:0] wb_rdat,
  input  logic               wb_ack
);

  cpu_pkg::arb_state_t state, next_state;
  logic                grant_instr, grant_data;

  assign grant_instr = (state == cpu_pkg::ARB_INSTR);
  assign grant_data  = (state == cpu_pkg::ARB_DATA);

  always_comb begin
    next_state = state;
    case (state)
      cpu_pkg::ARB_IDLE: begin
        // older instruction's data access first
        if (dbus.cyc) begin
          next_state = cpu_pkg::ARB_DATA;
        end else if (ibus.cyc) begin
          next_state = cpu_pkg::ARB_INSTR;
        end
      end
      cpu_pkg::ARB_INSTR: if (wb_ack || !ibus.cyc) next_state = cpu_pkg::ARB_IDLE;
      cpu_pkg::ARB_DATA:  if (wb_ack || !dbus.cyc) next_state = cpu_pkg::ARB_IDLE;
      default:            next_state = cpu_pkg::ARB_IDLE;
    endcase
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state <= cpu_pkg::ARB_IDLE;
    end else begin
      state <= next_state;
    end
  end

  // external bus stays quiet in idle
  assign wb_cyc  = (grant_instr & ibus.cyc) | (grant_data & dbus.cyc);
  assign wb_stb  = (grant_instr & ibus.stb) | (grant_data & dbus.stb);
  assign wb_we   = (grant_instr & ibus.we) | (grant_data & dbus.we);
  assign wb_adr  = grant_data ? dbus.adr : ibus.adr;
  assign wb_wdat = grant_data ? dbus.wdat : ibus.wdat;

  // ack only to the granted master
  assign ibus.rdat = wb_rdat;
  assign dbus.rdat = wb_rdat;
  assign ibus.ack  = grant_instr & wb_ack;
  assign dbus.ack  = grant_data & wb_ack;

endmodule

// File: logic/register_file.sv
/*
  register file
  two read ports, one write port, register 0 reads as zero
*/

`timescale 1ns/1ps
`include "cpu_defs.svh"

module register_file (
  input  logic                  CLK,
  input  logic                  nRST,
  input  logic [`REG_ADDR_W-1:0] rsel1,
  input  logic [`REG_ADDR_W-1:0] rsel2,
  output logic [`WORD_W-1:0]     rdat1,
  output logic [`WORD_W-1:0]     rdat2,
  input  logic                  wen,
  input  logic [`REG_ADDR_W-1:0] wsel,
  input  logic [`WORD_W-1:0]     wdat
);

  // register 0 has no storage
  logic [`WORD_W-1:0] regs [1:`NUM_REGS-1];

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      for (int i = 1; i < `NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && wsel != '0) begin
      regs[wsel] <= wdat;
    end
  end

  // no write-through, the datapath forwards instead
  assign rdat1 = (rsel1 == '0) ? '0 : regs[rsel1];
  assign rdat2 = (rsel2 == '0) ? '0 : regs[rsel2];

endmodule

// File: logic/wb_if.sv
/*
  wishbone classic bus
  one master, one slave, word addressed
*/

`timescale 1ns/1ps
`include "cpu_defs.svh"

interface wb_if;
  logic              cyc;
  logic              stb;
  logic              we;
  logic [`WORD_W-1:0] adr;
  logic [`WORD_W-1:0] wdat;
  logic [`WORD_W-1:0] rdat;
  logic              ack;

  modport master (
    output cyc, stb, we, adr, wdat,
    input  rdat, ack
  );

  modport slave (
    input  cyc, stb, we, adr, wdat,
    output rdat, ack
  );
endinterface

// File: tests/cpu_top_sva.sv
/*
  cpu bus checks
  wishbone request stability on the external bus and an idle
  arbiter cycle after each completed transfer
*/

`timescale 1ns/1ps
`include "cpu_defs.svh"

module cpu_top_sva (
  input logic               CLK,
  input logic               nRST,
  input logic               wb_cyc,
  input logic               wb_stb,
  input logic               wb_we,
  input logic [`WORD_W-1:0] wb_adr,
  input logic [`WORD_W-1:0] wb_wdat,
  input logic               wb_ack,
  input logic               grant_instr,
  input logic               grant_data
);

  // a request stays up until its ack
  a_stb_held: assert property (@(posedge CLK) disable iff (!nRST)
    (wb_stb && !wb_ack) |=> wb_stb)
    else $error("wishbone stb dropped before ack");

  // address, direction and write data frozen while waiting
  a_req_stable: assert property (@(posedge CLK) disable iff (!nRST)
    (wb_stb && !wb_ack) |=> ($stable(wb_adr) && $stable(wb_we) && $stable(wb_wdat)))
    else $error("wishbone request changed before ack");

  a_stb_cyc: assert property (@(posedge CLK) disable iff (!nRST) wb_stb |-> wb_cyc)
    else $error("wishbone stb without cyc");

  // arbiter drops back to idle for one cycle after every ack
  a_idle_after_ack: assert property (@(posedge CLK) disable iff (!nRST)
    wb_ack |=> !(grant_instr || grant_data))
    else $error("arbiter granted again right after ack");

endmodule

bind memory_arbiter cpu_top_sva u_cpu_top_sva (
  .CLK, .nRST, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_wdat, .wb_ack,
  .grant_instr, .grant_data
);

// File: tests/cpu_top_tb.sv
/*
  cpu_top testbench
  random program from a fixed seed, checked against an instruction-level
  model, on a bus memory that inserts random wait states
*/

`timescale 1ns/1ps
`include "cpu_defs.svh"

module cpu_top_tb;

  localparam int MEM_WORDS = 1024;
  localparam int DATA_BASE = 32'h800;  // byte address of data region
  localparam int RES_BASE  = 32'hc00;  // byte address of result area
  localparam int TIMEOUT   = 20000;

  logic               CLK, nRST;
  logic               wb_cyc, wb_stb, wb_we, wb_ack, halt;
  logic [`WORD_W-1:0] wb_adr, wb_wdat, wb_rdat;

  integer             seed;
  int                 errors, test_errors, tests_run, tests_failed;
  int                 prog_len, wait_cnt, wait_target, forced_wait;
  logic               in_req, first_seen;
  logic [`WORD_W-1:0] first_adr;
  logic [`WORD_W-1:0] prog [0:MEM_WORDS-1];
  logic [`WORD_W-1:0] mem [0:MEM_WORDS-1];
  logic [`WORD_W-1:0] wr_adr_q[$], wr_dat_q[$];
  // model state
  logic [`WORD_W-1:0] model_mem [0:MEM_WORDS-1];
  logic [`WORD_W-1:0] mregs [0:31];
  logic [`WORD_W-1:0] exp_adr_q[$], exp_dat_q[$];

  cpu_top u_cpu_top (
    .CLK, .nRST, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_wdat,
    .wb_rdat, .wb_ack, .halt
  );

  initial CLK = 1'b0;
  always #50 CLK = ~CLK;

  // bus slave, ack after 0 to 3 wait cycles unless forced_wait fixes it
  always @(posedge CLK) begin
    #1;
    if (wb_ack) begin
      wb_ack = 1'b0;
    end else if (wb_cyc && wb_stb) begin
      if (!first_seen) begin
        first_seen = 1'b1;
        first_adr  = wb_adr;
      end
      if (!in_req) begin
        in_req      = 1'b1;
        wait_cnt    = 0;
        wait_target = (forced_wait >= 0) ? forced_wait : ($random(seed) & 3);
      end
      if (wait_cnt == wait_target) begin
        if (wb_we) begin
          mem[wb_adr[9:0]] = wb_wdat;
          wr_adr_q.push_back(wb_adr);
          wr_dat_q.push_back(wb_wdat);
        end else begin
          wb_rdat = mem[wb_adr[9:0]];
        end
        wb_ack = 1'b1;
        in_req = 1'b0;
      end else begin
        wait_cnt++;
      end
    end
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic report_problem(input string msg);
    $display("%s", msg);
    errors++;
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (errors == test_errors) begin
      $display("%s: ok", name);
    end else begin
      tests_failed++;
      $display("%s: %0d errors", name, errors - test_errors);
    end
    test_errors = errors;
  endtask

  function automatic logic [31:0] rtype_word(input cpu_pkg::funct_t f, input int rd, rs, rt);
    return {6'h00, rs[4:0], rt[4:0], rd[4:0], 5'd0, f};
  endfunction

  function automatic logic [31:0] itype_word(input cpu_pkg::opcode_t op, input int rt, rs,
                                             input logic [15:0] imm);
    return {op, rs[4:0], rt[4:0], imm};
  endfunction

  task automatic append_instr(input logic [31:0] w);
    prog[prog_len] = w;
    prog_len++;
  endtask

  task automatic append_alu_op();
    int          kind, rd, rs, rt;
    logic [15:0] imm;
    kind = $unsigned($random(seed)) % 9;
    rd   = 1 + $unsigned($random(seed)) % 31;
    rs   = $random(seed) & 31;
    rt   = $random(seed) & 31;
    imm  = $random(seed);
    case (kind)
      0: append_instr(rtype_word(cpu_pkg::ADDU, rd, rs, rt));
      1: append_instr(rtype_word(cpu_pkg::SUBU, rd, rs, rt));
      2: append_instr(rtype_word(cpu_pkg::AND, rd, rs, rt));
      3: append_instr(rtype_word(cpu_pkg::OR, rd, rs, rt));
      4: append_instr(rtype_word(cpu_pkg::XOR, rd, rs, rt));
      5: append_instr(rtype_word(cpu_pkg::SLT, rd, rs, rt));
      6: append_instr(itype_word(cpu_pkg::ADDIU, rd, rs, imm));
      7: append_instr(itype_word(cpu_pkg::ORI, rd, rs, imm));
      default: append_instr(itype_word(cpu_pkg::LUI, rd, 0, imm));
    endcase
  endtask

  task automatic build_program();
    int               kind, rs, rt, ra;
    logic [31:0]      val;
    logic [15:0]      off;
    cpu_pkg::opcode_t bop;
    prog_len = 0;
    for (int i = 0; i < MEM_WORDS; i++) prog[i] = 32'hdead_0000 | i;
    for (int r = 1; r < 32; r++) begin
      val = $random(seed);
      append_instr(itype_word(cpu_pkg::LUI, r, 0, val[31:16]));
      append_instr(itype_word(cpu_pkg::ORI, r, r, val[15:0]));
    end
    for (int n = 0; n < 48; n++) begin
      kind = $random(seed) & 7;
      if (kind < 4) begin
        append_alu_op();
      end else if (kind == 4) begin
        // store, reload, then use the loaded value right away
        rt  = $random(seed) & 31;
        ra  = 1 + $unsigned($random(seed)) % 31;
        off = DATA_BASE + 4 * ($random(seed) & 15);
        append_instr(itype_word(cpu_pkg::SW, rt, 0, off));
        append_instr(itype_word(cpu_pkg::LW, ra, 0, off));
        append_instr(rtype_word(cpu_pkg::ADDU, ra, ra, $random(seed) & 31));
      end else if (kind < 7) begin
        // forward branch over an alu op and a store
        bop = (kind == 5) ? cpu_pkg::BEQ : cpu_pkg::BNE;
        rs  = $random(seed) & 31;
        rt  = ($random(seed) & 1) ? rs : ($random(seed) & 31);
        off = DATA_BASE + 64 + 4 * ($random(seed) & 15);
        append_instr(itype_word(bop, rt, rs, 16'd2));
        append_alu_op();
        append_instr(itype_word(cpu_pkg::SW, $random(seed) & 31, 0, off));
      end else begin
        // jump over one store
        off = DATA_BASE + 128 + 4 * ($random(seed) & 15);
        append_instr({cpu_pkg::J, 26'(prog_len + 2)});
        append_instr(itype_word(cpu_pkg::SW, $random(seed) & 31, 0, off));
      end
    end
    for (int r = 0; r < 32; r++) append_instr(itype_word(cpu_pkg::SW, r, 0, RES_BASE + 4 * r));
    append_instr({`HALT_OPCODE, 26'd0});
  endtask

  // sequential instruction-set model
  task automatic run_model();
    logic [31:0] pc, ins, a, b, sx, addr;
    int          steps;
    for (int i = 0; i < MEM_WORDS; i++) model_mem[i] = prog[i];
    for (int r = 0; r < 32; r++) mregs[r] = '0;
    pc    = `PC_RESET;
    steps = 0;
    ins   = model_mem[pc[11:2]];
    while (ins[31:26] != `HALT_OPCODE && steps < TIMEOUT) begin
      a    = mregs[ins[25:21]];
      b    = mregs[ins[20:16]];
      sx   = {{16{ins[15]}}, ins[15:0]};
      addr = a + sx;
      pc   = pc + 4;
      case (ins[31:26])
        cpu_pkg::RTYPE: begin
          case (ins[5:0])
            cpu_pkg::ADDU: mregs[ins[15:11]] = a + b;
            cpu_pkg::SUBU: mregs[ins[15:11]] = a - b;
            cpu_pkg::AND:  mregs[ins[15:11]] = a & b;
            cpu_pkg::OR:   mregs[ins[15:11]] = a | b;
            cpu_pkg::XOR:  mregs[ins[15:11]] = a ^ b;
            cpu_pkg::SLT:  mregs[ins[15:11]] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default: ;
          endcase
        end
        cpu_pkg::ADDIU: mregs[ins[20:16]] = addr;
        cpu_pkg::ORI:   mregs[ins[20:16]] = a | {16'h0000, ins[15:0]};
        cpu_pkg::LUI:   mregs[ins[20:16]] = {ins[15:0], 16'h0000};
        cpu_pkg::LW:    mregs[ins[20:16]] = model_mem[addr[11:2]];
        cpu_pkg::SW: begin
          model_mem[addr[11:2]] = b;
          exp_adr_q.push_back(addr >> 2);
          exp_dat_q.push_back(b);
        end
        cpu_pkg::BEQ: if (a == b) pc = pc + (sx << 2);
        cpu_pkg::BNE: if (a != b) pc = pc + (sx << 2);
        cpu_pkg::J:   pc = {pc[31:28], ins[25:0], 2'b00};
        default: ;
      endcase
      mregs[0] = '0;
      steps++;
      ins = model_mem[pc[11:2]];
    end
  endtask

  task automatic start_run(input int waits);
    int n;
    forced_wait = waits;
    for (int i = 0; i < MEM_WORDS; i++) mem[i] = prog[i];
    wr_adr_q.delete();
    wr_dat_q.delete();
    nRST       = 1'b0;
    wb_ack     = 1'b0;
    first_seen = 1'b0;
    in_req     = 1'b0;
    repeat (8) @(posedge CLK);
    #1;
    check_value("wb_cyc", wb_cyc, 0);
    check_value("wb_stb", wb_stb, 0);
    check_value("wb_we", wb_we, 0);
    check_value("halt", halt, 0);
    nRST = 1'b1;
    for (n = 0; n < 100 && !first_seen; n++) @(posedge CLK);
    if (!first_seen) report_problem("no bus request after reset");
    else check_value("first wb_adr", first_adr, `PC_RESET >> 2);
  endtask

  task automatic wait_halt();
    int n;
    for (n = 0; n < TIMEOUT && !halt; n++) begin
      @(posedge CLK);
      #1;
    end
    if (!halt) report_problem("timeout waiting for halt");
  endtask

  initial begin
    seed = 32'h5e8b24da;
    errors = 0;
    test_errors = 0;
    tests_run = 0;
    tests_failed = 0;
    nRST = 1'b0;
    wb_ack = 1'b0;
    wb_rdat = '0;
    forced_wait = -1;
    build_program();
    run_model();

    start_run(-1);
    end_test("reset and first fetch");

    wait_halt();
    for (int r = 0; r < 32; r++)
      check_value($sformatf("result r%0d", r), mem[(RES_BASE >> 2) + r], mregs[r]);
    end_test("alu and immediate results");

    // bus writes in program order
    check_value("write count", wr_adr_q.size(), exp_adr_q.size());
    for (int i = 0; i < wr_dat_q.size() && i < exp_dat_q.size(); i++)
      check_value($sformatf("wb_wdat #%0d", i), wr_dat_q[i], exp_dat_q[i]);
    end_test("load and store");

    for (int i = 0; i < wr_adr_q.size() && i < exp_adr_q.size(); i++)
      check_value($sformatf("wb_adr #%0d", i), wr_adr_q[i], exp_adr_q[i]);
    end_test("branches and jumps");

    for (int n = 0; n < 20; n++) begin
      @(posedge CLK);
      #1;
      check_value("halt", halt, 1);
      check_value("wb_cyc", wb_cyc, 0);
    end
    end_test("halt");

    // same program with the slowest memory, final memory as the model left it
    start_run(3);
    wait_halt();
    for (int i = 0; i < MEM_WORDS; i++)
      check_value($sformatf("mem[%0d]", i), mem[i], model_mem[i]);
    end_test("back-pressure");

    $display("%0d tests run, %0d with errors, %0d errors in total",
             tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule
